//--- source/video_pkg.sv
package video_pkg;

  // One grey pixel
  typedef logic [7:0] pixel_t;

  // Codes the octave stage understands
  // Any code not listed passes the first pixel of the pair
  typedef enum logic [3:0] {
    OP_AVG      = 4'd0,  // Floor average
    OP_ABS_DIFF = 4'd1,
    OP_MAX      = 4'd2,
    OP_MIN      = 4'd3
  } pair_op_e;

  // Frame configuration as sampled from the switches
  typedef struct packed {
    pair_op_e pair_op;
    logic     octave_select;  // 0 selects 2x output, 1 selects 4x output
  } pipe_config_t;

  // Word address with the buffer select in bit 17
  typedef logic [17:0] sram_addr_t;

  // Same 32 bits seen as raw data or as four pixel lanes
  typedef union packed {
    logic [31:0]      raw;
    pixel_t [3:0]     lanes;  // Lane 0 in the low byte
  } pixel_word_u;

  // Masked write toward the SRAM arbiter
  typedef struct packed {
    logic [3:0]  mask;  // One bit per lane
    sram_addr_t  addr;
    pixel_word_u data;
  } sram_write_t;

endpackage

//--- source/static_image.sv
module static_image
  import video_pkg::*;
#(
  parameter int N_PIXEL     = 480000,
  parameter int FRAME_WIDTH = 800
) (
  input  logic   bg_clock,
  input  logic   reset,
  input  logic   source_start,
  output logic   source_start_ack,
  input  logic   source_ready,
  output pixel_t pixel,
  output logic   pixel_valid
);

  localparam int CW = $clog2(N_PIXEL + 1);
  localparam int XW = (FRAME_WIDTH > 1) ? $clog2(FRAME_WIDTH) : 1;
  localparam int RW = $clog2(N_PIXEL / FRAME_WIDTH + 2);

  logic          active;     // Frame still emitting
  logic [CW-1:0] count;
  logic [XW-1:0] column;
  logic [RW-1:0] row;
  logic [7:0]    pixel_sum;

  // Diagonal gradient
  assign pixel_sum = 8'(column) + 8'(row);

  always_ff @(posedge bg_clock) begin
    if (reset) begin
      source_start_ack <= 1'b0;
      active           <= 1'b0;
      pixel_valid      <= 1'b0;
      count            <= '0;
      column           <= '0;
      row              <= '0;
    end else begin
      pixel_valid <= 1'b0;
      if (!source_start_ack) begin
        if (source_start) begin
          source_start_ack <= 1'b1;
          active           <= 1'b1;
          count            <= '0;
          column           <= '0;
          row              <= '0;
        end
      end else if (active) begin
        if (source_ready) begin
          pixel_valid <= 1'b1;
          count       <= count + CW'(1);
          if (column == XW'(FRAME_WIDTH - 1)) begin
            column <= '0;
            row    <= row + RW'(1);
          end else begin
            column <= column + XW'(1);
          end
          if (count == CW'(N_PIXEL - 1)) active <= 1'b0;  // Last pixel of the frame
        end
      end else if (!source_start) begin
        source_start_ack <= 1'b0;  // Frame over and request gone
      end
    end
  end

  always_ff @(posedge bg_clock) begin
    if (active && source_ready) pixel <= pixel_sum;
  end

endmodule

//--- source/frame_config.sv
module frame_config
  import video_pkg::*;
(
  input  logic         bg_clock,
  input  logic         reset,
  input  pair_op_e     pair_op,
  input  logic         octave_select,
  input  logic         frame_done,
  output pipe_config_t cfg,
  output logic         clear
);

  pipe_config_t sampled;
  logic         done_q;

  assign sampled.pair_op       = pair_op;
  assign sampled.octave_select = octave_select;

  // Settings only move between frames
  always_ff @(posedge bg_clock) begin
    if (reset) begin
      cfg    <= sampled;  // Take the switches as they stand
      clear  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= frame_done;
      clear  <= 1'b0;
      if (frame_done && !done_q && (sampled != cfg)) begin
        cfg   <= sampled;
        clear <= 1'b1;  // Flush half pairs in the octave stages
      end
    end
  end

endmodule

//--- source/octave_stage.sv
module octave_stage
  import video_pkg::*;
(
  input  logic     bg_clock,
  input  logic     reset,
  input  logic     clear,
  input  pair_op_e pair_op,
  input  pixel_t   din,
  input  logic     din_valid,
  output pixel_t   dout,
  output logic     dout_valid,
  output pixel_t   next_octave_dout,
  output logic     next_octave_valid
);

  pixel_t     first;       // First pixel of the pair
  logic       have_first;
  logic [8:0] pair_sum;
  pixel_t     pair_avg;
  pixel_t     pair_max;
  pixel_t     pair_min;
  pixel_t     pair_result;
  logic       pair_done;

  assign pair_done = din_valid && have_first;

  assign pair_sum = {1'b0, first} + {1'b0, din};
  assign pair_avg = pair_sum[8:1];  // Floor average
  assign pair_max = (first > din) ? first : din;
  assign pair_min = (first > din) ? din : first;

  always_comb begin
    case (pair_op)
      OP_AVG:      pair_result = pair_avg;
      OP_ABS_DIFF: pair_result = pair_max - pair_min;
      OP_MAX:      pair_result = pair_max;
      OP_MIN:      pair_result = pair_min;
      default:     pair_result = first;
    endcase
  end

  always_ff @(posedge bg_clock) begin
    if (reset || clear) begin
      have_first        <= 1'b0;  // Drop any half pair
      dout_valid        <= 1'b0;
      next_octave_valid <= 1'b0;
    end else begin
      dout_valid        <= pair_done;
      next_octave_valid <= pair_done;
      if (din_valid) have_first <= !have_first;
    end
  end

  always_ff @(posedge bg_clock) begin
    if (din_valid && !have_first) first <= din;
    if (pair_done) begin
      dout             <= pair_result;
      next_octave_dout <= pair_avg;  // Half rate feed for the next octave
    end
  end

endmodule

//--- source/image_buffer_writer.sv
module image_buffer_writer
  import video_pkg::*;
#(
  parameter int N_PIXEL = 480000
) (
  input  logic         bg_clock,
  input  logic         reset,
  input  logic         start,
  output logic         start_ack,
  output logic         done,
  input  logic         done_ack,
  input  logic         back_buffer,
  input  pipe_config_t cfg,
  output logic         source_start,
  input  logic         source_start_ack,
  output logic         source_ready,
  input  pixel_t       pixel,
  input  logic         pixel_valid,
  input  logic         frame_pixels,
  output sram_write_t  sram_write,
  output logic         sram_valid,
  input  logic         sram_ready
);

  localparam int CW = $clog2(N_PIXEL / 2 + 1);

  localparam logic [1:0] W_IDLE = 2'd0;
  localparam logic [1:0] W_RUN  = 2'd1;
  localparam logic [1:0] W_DONE = 2'd2;

  logic [1:0]    state;
  logic [CW-1:0] pix_count;
  logic [CW-1:0] pix_target;  // Pixels expected this frame
  logic [2:0]    lane_count;
  logic [16:0]   word_index;
  pixel_word_u   acc;

  logic          take;
  logic [CW-1:0] pix_count_next;
  logic [2:0]    lane_count_next;
  pixel_word_u   acc_next;
  logic          out_free;
  logic          all_in;
  logic          issue;
  logic [4:0]    mask_bits;

  // Accumulator as it stands after this cycle's pixel
  always_comb begin
    take            = (state == W_RUN) && pixel_valid && (lane_count < 3'd4);
    acc_next        = acc;
    lane_count_next = lane_count;
    pix_count_next  = pix_count;
    if (take) begin
      acc_next.lanes[lane_count[1:0]] = pixel;
      lane_count_next = lane_count + 3'd1;
      pix_count_next  = pix_count + CW'(1);
    end
  end

  assign out_free  = !sram_valid || sram_ready;
  assign all_in    = (state == W_RUN) && (pix_count_next == pix_target);
  assign issue     = (state == W_RUN) && out_free &&
                     ((lane_count_next == 3'd4) || (all_in && (lane_count_next != 3'd0)));
  assign mask_bits = (5'd1 << lane_count_next) - 5'd1;

  // At most one pixel can still be on its way once this drops
  assign source_ready = !(sram_valid && (lane_count >= 3'd3));

  always_ff @(posedge bg_clock) begin
    if (reset) begin
      state        <= W_IDLE;
      start_ack    <= 1'b0;
      done         <= 1'b0;
      source_start <= 1'b0;
      sram_valid   <= 1'b0;
      lane_count   <= '0;
      pix_count    <= '0;
      pix_target   <= '0;
      word_index   <= '0;
    end else begin
      if (start_ack && !start) start_ack <= 1'b0;
      if (source_start && source_start_ack) source_start <= 1'b0;
      if (sram_valid && sram_ready) sram_valid <= 1'b0;
      if (issue) sram_valid <= 1'b1;  // Overrides the accept above

      case (state)
        W_IDLE: begin
          if (start && !start_ack) begin
            start_ack    <= 1'b1;
            source_start <= 1'b1;
            lane_count   <= '0;
            pix_count    <= '0;
            word_index   <= '0;
            pix_target   <= cfg.octave_select ? CW'(N_PIXEL / 4) : CW'(N_PIXEL / 2);
            state        <= W_RUN;
          end
        end
        W_RUN: begin
          pix_count  <= pix_count_next;
          lane_count <= issue ? 3'd0 : lane_count_next;
          if (issue) word_index <= word_index + 17'd1;
          // Last word taken by the arbiter and source idle
          if ((pix_count == pix_target) && (lane_count == 3'd0) && !sram_valid &&
              !frame_pixels) begin
            done  <= 1'b1;
            state <= W_DONE;
          end
        end
        W_DONE: begin
          if (done_ack) begin
            done  <= 1'b0;
            state <= W_IDLE;
          end
        end
        default: state <= W_IDLE;
      endcase
    end
  end

  always_ff @(posedge bg_clock) begin
    if (issue) begin
      acc.raw         <= '0;
      sram_write.mask <= mask_bits[3:0];
      sram_write.addr <= {back_buffer, word_index};
      sram_write.data <= acc_next;
    end else if (take) begin
      acc <= acc_next;
    end
  end

endmodule

//--- source/swap_controller.sv
module swap_controller (
  input  logic bg_clock,
  input  logic reset,
  output logic bg_start,
  input  logic bg_start_ack,
  input  logic bg_done,
  output logic bg_done_ack,
  output logic swap,
  input  logic swap_ack,
  output logic back_buffer
);

  localparam logic [2:0] S_START     = 3'd0;
  localparam logic [2:0] S_START_REL = 3'd1;
  localparam logic [2:0] S_WAIT_DONE = 3'd2;
  localparam logic [2:0] S_DONE_REL  = 3'd3;
  localparam logic [2:0] S_SWAP      = 3'd4;
  localparam logic [2:0] S_SWAP_REL  = 3'd5;

  logic [2:0] state;

  always_ff @(posedge bg_clock) begin
    if (reset) begin
      state       <= S_START;
      bg_start    <= 1'b0;
      bg_done_ack <= 1'b0;
      swap        <= 1'b0;
      back_buffer <= 1'b0;
    end else begin
      case (state)
        S_START: begin
          bg_start <= 1'b1;
          if (bg_start_ack) begin
            bg_start <= 1'b0;
            state    <= S_START_REL;
          end
        end
        S_START_REL: begin
          if (!bg_start_ack) state <= S_WAIT_DONE;  // Writer has let go
        end
        S_WAIT_DONE: begin
          if (bg_done) begin
            bg_done_ack <= 1'b1;
            state       <= S_DONE_REL;
          end
        end
        S_DONE_REL: begin
          if (!bg_done) begin
            bg_done_ack <= 1'b0;
            state       <= S_SWAP;
          end
        end
        S_SWAP: begin
          swap <= 1'b1;  // Ask the display side to flip
          if (swap_ack) begin
            swap  <= 1'b0;
            state <= S_SWAP_REL;
          end
        end
        S_SWAP_REL: begin
          if (!swap_ack) begin
            back_buffer <= !back_buffer;  // Draw into the buffer just released
            state       <= S_START;
          end
        end
        default: state <= S_START;
      endcase
    end
  end

endmodule

//--- source/bg_pipeline_top.sv
module bg_pipeline_top
  import video_pkg::*;
#(
  parameter int N_PIXEL     = 480000,
  parameter int FRAME_WIDTH = 800
) (
  input  logic        bg_clock,
  input  logic        reset,
  input  pair_op_e    pair_op,
  input  logic        octave_select,
  output sram_write_t sram_write,
  output logic        sram_valid,
  input  logic        sram_ready,
  output logic        swap,
  input  logic        swap_ack
);

  logic         bg_start;
  logic         bg_start_ack;
  logic         bg_done;
  logic         bg_done_ack;
  logic         back_buffer;
  logic         source_start;
  logic         source_start_ack;
  logic         source_ready;
  pixel_t       src_pixel;
  logic         src_valid;
  pipe_config_t cfg;
  logic         stage_clear;
  pixel_t       oct2_pixel;
  logic         oct2_valid;
  pixel_t       mid_pixel;   // Averaged feed between octaves
  logic         mid_valid;
  pixel_t       oct4_pixel;
  logic         oct4_valid;
  pixel_t       wr_pixel;
  logic         wr_valid;

  swap_controller i_swap_controller (
    .bg_clock     (bg_clock),
    .reset        (reset),
    .bg_start     (bg_start),
    .bg_start_ack (bg_start_ack),
    .bg_done      (bg_done),
    .bg_done_ack  (bg_done_ack),
    .swap         (swap),
    .swap_ack     (swap_ack),
    .back_buffer  (back_buffer)
  );

  frame_config i_frame_config (
    .bg_clock      (bg_clock),
    .reset         (reset),
    .pair_op       (pair_op),
    .octave_select (octave_select),
    .frame_done    (bg_done),
    .cfg           (cfg),
    .clear         (stage_clear)
  );

  static_image #(
    .N_PIXEL     (N_PIXEL),
    .FRAME_WIDTH (FRAME_WIDTH)
  ) i_static_image (
    .bg_clock         (bg_clock),
    .reset            (reset),
    .source_start     (source_start),
    .source_start_ack (source_start_ack),
    .source_ready     (source_ready),
    .pixel            (src_pixel),
    .pixel_valid      (src_valid)
  );

  octave_stage i_octave_2x (
    .bg_clock          (bg_clock),
    .reset             (reset),
    .clear             (stage_clear),
    .pair_op           (cfg.pair_op),
    .din               (src_pixel),
    .din_valid         (src_valid),
    .dout              (oct2_pixel),
    .dout_valid        (oct2_valid),
    .next_octave_dout  (mid_pixel),
    .next_octave_valid (mid_valid)
  );

  octave_stage i_octave_4x (
    .bg_clock          (bg_clock),
    .reset             (reset),
    .clear             (stage_clear),
    .pair_op           (cfg.pair_op),
    .din               (mid_pixel),
    .din_valid         (mid_valid),
    .dout              (oct4_pixel),
    .dout_valid        (oct4_valid),
    .next_octave_dout  (),
    .next_octave_valid ()
  );

  assign wr_pixel = cfg.octave_select ? oct4_pixel : oct2_pixel;
  assign wr_valid = cfg.octave_select ? oct4_valid : oct2_valid;

  image_buffer_writer #(
    .N_PIXEL (N_PIXEL)
  ) i_image_buffer_writer (
    .bg_clock         (bg_clock),
    .reset            (reset),
    .start            (bg_start),
    .start_ack        (bg_start_ack),
    .done             (bg_done),
    .done_ack         (bg_done_ack),
    .back_buffer      (back_buffer),
    .cfg              (cfg),
    .source_start     (source_start),
    .source_start_ack (source_start_ack),
    .source_ready     (source_ready),
    .pixel            (wr_pixel),
    .pixel_valid      (wr_valid),
    .frame_pixels     (source_start_ack),  // Ack stays up while the source emits
    .sram_write       (sram_write),
    .sram_valid       (sram_valid),
    .sram_ready       (sram_ready)
  );

endmodule

//--- tb/bg_checks.svh
// Reference model and directed tests for tb_bg_pipeline

function automatic logic [31:0] lfsr_step(input logic [31:0] state);
  // Galois form of x^32 + x^22 + x^2 + x + 1
  if (state[0]) begin
    return (state >> 1) ^ 32'h8020_0003;
  end
  return state >> 1;
endfunction

// Diagonal gradient of the static image
function automatic pixel_t source_pixel(input int index);
  int column;
  int row;
  column = index % FRAME_W;
  row    = index / FRAME_W;
  return pixel_t'((column + row) & 255);
endfunction

function automatic pixel_t pair_value(input logic [3:0] op, input pixel_t a, input pixel_t b);
  logic [8:0] sum;
  sum = {1'b0, a} + {1'b0, b};
  case (op)
    4'd0:    return sum[8:1];  // Floor average
    4'd1:    return (a > b) ? a - b : b - a;
    4'd2:    return (a > b) ? a : b;
    4'd3:    return (a > b) ? b : a;
    default: return a;
  endcase
endfunction

task automatic fill_expected(input logic [3:0] op, input logic osel);
  int     i;
  pixel_t avg_a;
  pixel_t avg_b;
  expected_pixels.delete();
  if (!osel) begin
    for (i = 0; i < N_PIX / 2; i++) begin
      expected_pixels.push_back(pair_value(op, source_pixel(2 * i), source_pixel(2 * i + 1)));
    end
  end else begin
    for (i = 0; i < N_PIX / 4; i++) begin
      avg_a = pair_value(4'd0, source_pixel(4 * i), source_pixel(4 * i + 1));
      avg_b = pair_value(4'd0, source_pixel(4 * i + 2), source_pixel(4 * i + 3));
      expected_pixels.push_back(pair_value(op, avg_a, avg_b));  // Second octave sees averages
    end
  end
endtask

task automatic expect_equal(input string name, input logic [63:0] got, input logic [63:0] exp);
  checks = checks + 1;
  assert (got === exp) else begin
    $display("error at %0t: %s expected %0h got %0h", $time, name, exp, got);
    errors = errors + 1;
  end
endtask

task automatic expect_true(input logic cond, input string what);
  checks = checks + 1;
  assert (cond) else begin
    $display("error at %0t: %s", $time, what);
    errors = errors + 1;
  end
endtask

task automatic report_test(input string name, input int errors_before);
  tests_run = tests_run + 1;
  if (errors == errors_before) begin
    $display("%s: ok", name);
  end else begin
    tests_failed = tests_failed + 1;
    $display("%s: %0d errors", name, errors - errors_before);
  end
endtask

// Collects and checks one frame and queues the setting for the next
task automatic receive_frame(input logic [3:0] op, input logic osel,
                             input logic [3:0] next_op, input logic next_osel, input int frame);
  word_record_t rec;
  sram_addr_t   addr_exp;
  logic [3:0]   mask_exp;
  int           n_words;
  int           lanes;
  int           w;
  int           l;
  fill_expected(op, osel);
  n_words = (expected_pixels.size() + 3) / 4;
  frame_words.delete();
  while (words.size() == 0) @(posedge bg_clock);
  #1;
  pair_op       = pair_op_e'(next_op);  // Sampled when this frame reports done
  octave_select = next_osel;
  while (words.size() < n_words) @(posedge bg_clock);
  for (w = 0; w < n_words; w++) begin
    rec = words.pop_front();
    frame_words.push_back(rec);
    lanes = expected_pixels.size() - 4 * w;
    if (lanes > 4) lanes = 4;
    addr_exp = {frame[0], w[16:0]};
    mask_exp = 4'b0000;
    expect_equal($sformatf("sram_write.addr (frame %0d word %0d)", frame, w),
                 32'(rec.xfer.addr), 32'(addr_exp));
    for (l = 0; l < lanes; l++) begin
      mask_exp[l] = 1'b1;  // Only filled lanes are written
      expect_equal($sformatf("sram_write.data.lanes[%0d] (frame %0d word %0d)", l, frame, w),
                   32'(rec.xfer.data.lanes[l]), 32'(expected_pixels[4 * w + l]));
    end
    expect_equal($sformatf("sram_write.mask (frame %0d word %0d)", frame, w),
                 32'(rec.xfer.mask), 32'(mask_exp));
  end
endtask

task automatic check_2x_average();
  int errors_before;
  errors_before = errors;
  receive_frame(4'd0, 1'b0, 4'd1, 1'b0, 0);
  report_test("2x floor average", errors_before);
endtask

task automatic sweep_pair_ops();
  logic [3:0] ops [4];
  int         errors_before;
  int         i;
  errors_before = errors;
  ops = '{4'd1, 4'd2, 4'd3, 4'd7};  // Difference, max, min, pass first
  for (i = 0; i < 4; i++) begin
    if (i < 3) begin
      receive_frame(ops[i], 1'b0, ops[i + 1], 1'b0, i + 1);
    end else begin
      receive_frame(ops[i], 1'b0, 4'd0, 1'b1, i + 1);  // Queue the 4x chain
    end
  end
  report_test("pair operations", errors_before);
endtask

task automatic chain_4x_partial();
  int errors_before;
  errors_before = errors;
  receive_frame(4'd0, 1'b1, 4'd0, 1'b0, 5);
  while (swap_reqs < 8'd6) @(posedge bg_clock);  // Frame over once its swap is requested
  expect_equal("word count of the 4x frame",
               32'(frame_words.size() + words.size()), 32'd5);
  expect_equal("sram_write.mask of the 4x tail word", 32'(frame_words[4].xfer.mask), 32'h3);
  report_test("4x chain with partial word", errors_before);
endtask

task automatic stall_sram_ready();
  int errors_before;
  errors_before = errors;
  stall_hits    = 0;
  stall_enable  = 1'b1;
  receive_frame(4'd0, 1'b0, 4'd0, 1'b0, 6);
  receive_frame(4'd0, 1'b0, 4'd0, 1'b0, 7);
  stall_enable = 1'b0;
  expect_true(stall_hits > 0, "sram_ready never held back a pending word");
  report_test("sram back-pressure", errors_before);
endtask

task automatic swap_double_buffer();
  logic [2:0] banks;
  int         errors_before;
  int         i;
  int         w;
  errors_before = errors;
  banks = 3'b010;  // Buffer 0, 1, 0
  for (i = 0; i < 3; i++) begin
    receive_frame(4'd0, 1'b0, 4'd0, 1'b0, 8 + i);
    for (w = 0; w < frame_words.size(); w++) begin
      expect_equal($sformatf("sram_write.addr[17] (frame %0d word %0d)", 8 + i, w),
                   32'(frame_words[w].xfer.addr[17]), 32'(banks[i]));
      expect_true(frame_words[w].swap_acks == 8'(8 + i),
                  "a word was accepted before the previous swap was acknowledged");
      expect_true(frame_words[w].swap_reqs == 8'(8 + i),
                  "the swap requests did not come exactly once per frame");
    end
  end
  while (swap_reqs < 8'd11) @(posedge bg_clock);
  expect_true(words.size() == 0, "words of the next frame came before its swap");
  report_test("double buffer and swap", errors_before);
endtask

//--- tb/tb_bg_pipeline.sv
module tb_bg_pipeline
  import video_pkg::*;
();

  localparam int N_PIX          = 72;
  localparam int FRAME_W        = 12;
  localparam int RESET_CYCLES   = 10;
  localparam int FRAME_COUNT    = 12;          // Eleven checked frames and the swap after them
  localparam int FRAME_CYCLES   = N_PIX + 40;  // Source pixels plus handshake overhead
  localparam int TIMEOUT_CYCLES = 4 * FRAME_COUNT * FRAME_CYCLES + RESET_CYCLES;
  localparam logic [31:0] LFSR_SEED = 32'd77984;

  // One accepted SRAM word with the swap state at the time
  typedef struct packed {
    sram_write_t xfer;
    logic [7:0]  swap_reqs;  // Swap requests seen before the word
    logic [7:0]  swap_acks;  // Swap acknowledges given before the word
  } word_record_t;

  logic        bg_clock = 1'b0;
  logic        reset;
  pair_op_e    pair_op;
  logic        octave_select;
  sram_write_t sram_write;
  logic        sram_valid;
  logic        sram_ready;
  logic        swap;
  logic        swap_ack;

  logic        stall_enable;
  logic [31:0] lfsr_state;
  logic        swap_seen     = 1'b0;
  logic [7:0]  swap_reqs     = 8'd0;
  logic [7:0]  swap_acks     = 8'd0;
  logic        stall_pending = 1'b0;
  sram_write_t stalled_write;
  int          ack_delay     = 0;
  int          stall_hits    = 0;
  int          cycle_count   = 0;
  int          errors        = 0;
  int          checks        = 0;
  int          tests_run     = 0;
  int          tests_failed  = 0;

  word_record_t words[$];        // Every word the SRAM side accepted in order
  word_record_t frame_words[$];  // Words of the frame checked last
  pixel_t       expected_pixels[$];

  always #5 bg_clock = ~bg_clock;

  bg_pipeline_top #(
    .N_PIXEL     (N_PIX),
    .FRAME_WIDTH (FRAME_W)
  ) i_dut (
    .bg_clock      (bg_clock),
    .reset         (reset),
    .pair_op       (pair_op),
    .octave_select (octave_select),
    .sram_write    (sram_write),
    .sram_valid    (sram_valid),
    .sram_ready    (sram_ready),
    .swap          (swap),
    .swap_ack      (swap_ack)
  );

  `include "bg_checks.svh"

  // SRAM side accepting or stalling words
  always begin
    @(posedge bg_clock);
    #1;
    if (stall_enable) begin
      sram_ready = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end else begin
      sram_ready = 1'b1;
    end
  end

  // Display side answers a swap a few cycles late
  always begin
    @(posedge bg_clock);
    #1;
    if (swap && !swap_ack) begin
      ack_delay = ack_delay + 1;
      if (ack_delay == 3) begin
        swap_ack  = 1'b1;
        swap_acks = swap_acks + 8'd1;
        ack_delay = 0;
      end
    end else if (!swap && swap_ack) begin
      swap_ack = 1'b0;
    end
  end

  // Sampled mid cycle where outputs are settled
  always @(negedge bg_clock) begin
    if (!reset) begin
      if (stall_pending) begin
        expect_true(sram_valid, "sram_valid fell while a stalled word was still pending");
        expect_equal("sram_write", 64'(sram_write), 64'(stalled_write));  // Held while stalled
      end
      stall_pending = sram_valid && !sram_ready;
      stalled_write = sram_write;
      if (swap && !swap_seen) swap_reqs = swap_reqs + 8'd1;
      swap_seen = swap;
      if (sram_valid && sram_ready) begin
        words.push_back('{xfer: sram_write, swap_reqs: swap_reqs, swap_acks: swap_acks});
      end
      if (sram_valid && !sram_ready) stall_hits = stall_hits + 1;
    end
  end

  always @(posedge bg_clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    reset         = 1'b1;
    pair_op       = OP_AVG;  // Frame 0 setting sampled during reset
    octave_select = 1'b0;
    sram_ready    = 1'b1;
    swap_ack      = 1'b0;
    stall_enable  = 1'b0;
    lfsr_state    = LFSR_SEED;
    repeat (RESET_CYCLES) @(posedge bg_clock);
    #1;
    reset = 1'b0;

    check_2x_average();
    sweep_pair_ops();
    chain_4x_partial();
    stall_sram_ready();
    swap_double_buffer();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+tb
source/video_pkg.sv
source/static_image.sv
source/frame_config.sv
source/octave_stage.sv
source/image_buffer_writer.sv
source/swap_controller.sv
source/bg_pipeline_top.sv
tb/tb_bg_pipeline.sv
